/* verilog/uart_pkg.sv */
package uart_pkg;

    localparam int data_w = 8;
    localparam int cbp_w = 16;
    localparam int idx_w = $clog2(data_w);   // bit index inside a frame

    localparam logic [idx_w-1:0] last_idx = idx_w'(data_w - 1);

    // frame position, shared by receiver and transmitter
    typedef enum logic [1:0] {
        line_idle,
        line_start,
        line_data,
        line_stop
    } line_state_t;

    typedef enum logic {
        stop_one,
        stop_two
    } stop_bits_t;

    typedef struct packed {
        logic [cbp_w-1:0] cbp;               // clocks per bit minus one
        stop_bits_t       stop_bits;
    } uart_cfg_t;

    typedef struct packed {
        logic [data_w-1:0] rx_data;
        logic              rx_ready;         // a byte is held
        logic              overrun;
        logic              frame_err;
        logic              tx_busy;
        logic              tx_done;          // sticky until next start
    } uart_status_t;

endpackage

/* verilog/uart_rx.sv */
module uart_rx (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  uart_pkg::uart_cfg_t         cfg_i,
    input  logic                        rx_i,
    output logic [uart_pkg::data_w-1:0] rx_byte_o,
    output logic                        rx_done_o,
    output logic                        rx_bad_stop_o
);

    logic                        rx_meta;
    logic                        rx_sync;
    logic                        rx_prev;
    logic                        fall;
    logic                        tick;
    logic [uart_pkg::cbp_w-1:0]  cnt_q;
    logic [uart_pkg::idx_w-1:0]  idx_q;
    logic [uart_pkg::data_w-1:0] shift_q;
    uart_pkg::line_state_t       state_q;

    // two-flop synchronizer plus one more stage for edge detection
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = rx_prev & ~rx_sync;
    assign tick = (cnt_q == cfg_i.cbp);

    // preload in idle puts every tick at mid-bit
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (state_q == uart_pkg::line_idle) begin
            cnt_q <= cfg_i.cbp >> 1;
        end else if (tick) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= uart_pkg::line_idle;
            idx_q     <= '0;
            rx_done_o <= 1'b0;
        end else begin
            rx_done_o <= 1'b0;
            case (state_q)
                uart_pkg::line_idle: begin
                    if (fall) begin
                        state_q <= uart_pkg::line_start;
                    end
                end
                uart_pkg::line_start: begin
                    if (tick) begin
                        // glitch shorter than half a bit goes back to idle
                        state_q <= rx_sync ? uart_pkg::line_idle : uart_pkg::line_data;
                        idx_q   <= '0;
                    end
                end
                uart_pkg::line_data: begin
                    if (tick) begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == uart_pkg::last_idx) begin
                            state_q <= uart_pkg::line_stop;
                        end
                    end
                end
                uart_pkg::line_stop: begin
                    if (tick) begin
                        state_q   <= uart_pkg::line_idle;
                        rx_done_o <= 1'b1;
                    end
                end
                default: state_q <= uart_pkg::line_idle;
            endcase
        end
    end

    // payload, lsb arrives first
    always_ff @(posedge clk_i) begin
        if (state_q == uart_pkg::line_data && tick) begin
            shift_q <= {rx_sync, shift_q[uart_pkg::data_w-1:1]};
        end
        if (state_q == uart_pkg::line_stop && tick) begin
            rx_byte_o     <= shift_q;
            rx_bad_stop_o <= ~rx_sync;   // stop bit must be high
        end
    end

endmodule

/* verilog/uart_tx.sv */
module uart_tx (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  uart_pkg::uart_cfg_t         cfg_i,
    input  logic                        tx_start_i,
    input  logic [uart_pkg::data_w-1:0] tx_data_i,
    output logic                        tx_o,
    output logic                        tx_busy_o,
    output logic                        tx_end_o
);

    uart_pkg::line_state_t       state_q;
    logic [uart_pkg::cbp_w-1:0]  cnt_q;
    logic [uart_pkg::idx_w-1:0]  idx_q;
    logic [uart_pkg::data_w-1:0] shift_q;
    logic                        tick;
    logic                        start_ok;
    logic                        last_stop;

    assign tick      = (cnt_q == cfg_i.cbp);
    assign start_ok  = tx_start_i && (state_q == uart_pkg::line_idle);
    assign last_stop = (cfg_i.stop_bits == uart_pkg::stop_one) || idx_q[0];

    assign tx_busy_o = (state_q != uart_pkg::line_idle);
    // last cycle of the last stop bit, idle follows
    assign tx_end_o  = (state_q == uart_pkg::line_stop) && tick && last_stop;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (state_q == uart_pkg::line_idle || tick) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            shift_q <= tx_data_i;
        end else if (state_q == uart_pkg::line_data && tick) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= uart_pkg::line_idle;
            idx_q   <= '0;
            tx_o    <= 1'b1;
        end else begin
            case (state_q)
                uart_pkg::line_idle: begin
                    if (tx_start_i) begin
                        state_q <= uart_pkg::line_start;
                        tx_o    <= 1'b0;         // start bit
                    end
                end
                uart_pkg::line_start: begin
                    if (tick) begin
                        state_q <= uart_pkg::line_data;
                        idx_q   <= '0;
                        tx_o    <= shift_q[0];
                    end
                end
                uart_pkg::line_data: begin
                    if (tick) begin
                        if (idx_q == uart_pkg::last_idx) begin
                            state_q <= uart_pkg::line_stop;
                            idx_q   <= '0;       // reused as stop bit count
                            tx_o    <= 1'b1;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                            tx_o  <= shift_q[1]; // shift happens on this edge
                        end
                    end
                end
                uart_pkg::line_stop: begin
                    if (tick) begin
                        if (last_stop) begin
                            state_q <= uart_pkg::line_idle;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= uart_pkg::line_idle;
                    tx_o    <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* verilog/uart_status.sv */
module uart_status (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [uart_pkg::data_w-1:0] rx_byte_i,
    input  logic                        rx_done_i,
    input  logic                        rx_bad_stop_i,
    input  logic                        rx_read_i,
    input  logic                        tx_busy_i,
    input  logic                        tx_end_i,
    input  logic                        tx_start_i,
    output uart_pkg::uart_status_t      status_o,
    output logic                        irq_o
);

    logic [uart_pkg::data_w-1:0] rx_data_q;
    logic                        rx_ready_q;
    logic                        overrun_q;
    logic                        frame_err_q;
    logic                        tx_done_q;

    // one-entry holding register, overwritten without back-pressure
    always_ff @(posedge clk_i) begin
        if (rx_done_i) begin
            rx_data_q <= rx_byte_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_ready_q  <= 1'b0;
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
            tx_done_q   <= 1'b0;
        end else begin
            if (rx_read_i) begin
                rx_ready_q  <= 1'b0;
                overrun_q   <= 1'b0;
                frame_err_q <= 1'b0;
            end
            if (rx_done_i) begin
                rx_ready_q <= 1'b1;
                if (rx_ready_q && !rx_read_i) begin
                    overrun_q <= 1'b1;  // old byte lost
                end
                if (rx_bad_stop_i) begin
                    frame_err_q <= 1'b1;
                end
            end
            if (tx_end_i) begin
                tx_done_q <= 1'b1;
            end else if (tx_start_i && !tx_busy_i) begin
                tx_done_q <= 1'b0;      // only an accepted start clears it
            end
        end
    end

    always_comb begin
        status_o.rx_data   = rx_data_q;
        status_o.rx_ready  = rx_ready_q;
        status_o.overrun   = overrun_q;
        status_o.frame_err = frame_err_q;
        status_o.tx_busy   = tx_busy_i;
        status_o.tx_done   = tx_done_q;
    end

    assign irq_o = rx_ready_q | frame_err_q;

endmodule

/* verilog/uart_top.sv */
module uart_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  uart_pkg::uart_cfg_t         cfg_i,
    input  logic                        tx_start_i,
    input  logic [uart_pkg::data_w-1:0] tx_data_i,
    input  logic                        rx_read_i,
    input  logic                        rx_i,
    output logic                        tx_o,
    output uart_pkg::uart_status_t      status_o,
    output logic                        irq_o
);

    logic [uart_pkg::data_w-1:0] rx_byte;
    logic                        rx_done;
    logic                        rx_bad_stop;
    logic                        tx_busy;
    logic                        tx_end;

    // receiver and transmitter share the bit period from cfg_i
    uart_rx u_rx (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cfg_i         (cfg_i),
        .rx_i          (rx_i),
        .rx_byte_o     (rx_byte),
        .rx_done_o     (rx_done),
        .rx_bad_stop_o (rx_bad_stop)
    );

    uart_tx u_tx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg_i      (cfg_i),
        .tx_start_i (tx_start_i),
        .tx_data_i  (tx_data_i),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy),
        .tx_end_o   (tx_end)
    );

    uart_status u_status (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rx_byte_i     (rx_byte),
        .rx_done_i     (rx_done),
        .rx_bad_stop_i (rx_bad_stop),
        .rx_read_i     (rx_read_i),
        .tx_busy_i     (tx_busy),
        .tx_end_i      (tx_end),
        .tx_start_i    (tx_start_i),
        .status_o      (status_o),
        .irq_o         (irq_o)
    );

endmodule

/* bench/uart_assert.sv */
module uart_assert (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   tx_line_i,
    input logic                   tx_busy_i,
    input logic                   rx_done_i,
    input logic                   tx_end_i,
    input logic                   irq_i,
    input uart_pkg::uart_status_t status_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // line idles high between frames
    tx_idle_high: assert property (
        @(posedge clk_i) disable iff (rst_i) !tx_busy_i |-> tx_line_i
    ) else $error("tx_o low while the transmitter is idle");

    // both end markers are single-cycle pulses
    single_pulse: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !((rx_done_i && $past(rx_done_i)) || (tx_end_i && $past(tx_end_i)))
    ) else $error("rx_done or tx_end high for two cycles in a row");

    // a received byte raises the interrupt in the next cycle
    irq_on_rx: assert property (
        @(posedge clk_i) disable iff (rst_i)
        rx_done_i |=> (irq_i && status_i.rx_ready)
    ) else $error("irq_o or rx_ready not raised in the cycle after rx_done");

endmodule

bind uart_top uart_assert u_assert (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .tx_line_i (tx_o),
    .tx_busy_i (tx_busy),
    .rx_done_i (rx_done),
    .tx_end_i  (tx_end),
    .irq_i     (irq_o),
    .status_i  (status_o)
);

/* bench/uart_tb.sv */
module uart_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_rounds = 4;
    localparam int frames_per_round = 10;
    localparam int max_cbp = 20;
    // twelve bit periods per frame on average, gaps included
    localparam int max_cycles = n_rounds * frames_per_round * 12 * (max_cbp + 1) + 1000;

    logic                        clk_i;
    logic                        rst_i;
    uart_pkg::uart_cfg_t         cfg;
    logic                        tx_start;
    logic [uart_pkg::data_w-1:0] tx_data;
    logic                        rx_read;
    logic                        rx_line;
    logic                        tx_line;
    uart_pkg::uart_status_t      status;
    logic                        irq;

    // reference model of the receive side
    logic                        exp_ready;
    logic                        exp_overrun;
    logic                        exp_frame_err;
    logic [uart_pkg::data_w-1:0] exp_data;
    int                          rx_done_seen = 0;
    int                          cycles = 0;

    uart_top u_dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg_i      (cfg),
        .tx_start_i (tx_start),
        .tx_data_i  (tx_data),
        .rx_read_i  (rx_read),
        .rx_i       (rx_line),
        .tx_o       (tx_line),
        .status_o   (status),
        .irq_o      (irq)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(negedge clk_i) begin
        if (!rst_i && u_dut.rx_done) begin
            rx_done_seen <= rx_done_seen + 1;   // counted one edge late
        end
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", max_cycles);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_rx_status();
        check_value("rx_ready", 32'(status.rx_ready), 32'(exp_ready));
        check_value("overrun", 32'(status.overrun), 32'(exp_overrun));
        check_value("frame_err", 32'(status.frame_err), 32'(exp_frame_err));
        check_value("irq_o", 32'(irq), 32'(exp_ready | exp_frame_err));
        if (exp_ready) begin
            check_value("rx_data", 32'(status.rx_data), 32'(exp_data));
        end
    endtask

    // sends one frame and decodes tx_o at mid-bit
    task automatic tx_frame(input logic [uart_pkg::data_w-1:0] data, input bit poke);
        int p;
        int last;
        int bit_idx;
        logic [uart_pkg::data_w-1:0] got;
        p = int'(cfg.cbp) + 1;
        last = ((cfg.stop_bits == uart_pkg::stop_two) ? 11 : 10) * p;
        got = '0;
        tx_data = data;
        tx_start = 1'b1;
        @(negedge clk_i);
        tx_start = 1'b0;
        tx_data = ~data;                        // must have been latched already
        for (int i = 0; i <= last; i++) begin
            if (poke) begin
                tx_start = (i == 3 * p);        // start pulse while busy
            end
            if (i % p == p / 2) begin
                bit_idx = i / p;
                if (bit_idx == 0) begin
                    check_value("tx_o start bit", 32'(tx_line), 32'(0));
                end else if (bit_idx <= uart_pkg::data_w) begin
                    got[bit_idx - 1] = tx_line;
                end else begin
                    check_value("tx_o stop bit", 32'(tx_line), 32'(1));
                end
            end
            check_value("tx_busy", 32'(status.tx_busy), 32'(i < last));
            check_value("tx_done", 32'(status.tx_done), 32'(i == last));
            if (i < last) begin
                @(negedge clk_i);
            end
        end
        check_value("tx_o decoded byte", 32'(got), 32'(data));
        if (poke) begin
            // the ignored start must not produce a second frame
            repeat (2 * p) begin
                @(negedge clk_i);
                check_value("tx_o after frame", 32'(tx_line), 32'(1));
                check_value("tx_busy after frame", 32'(status.tx_busy), 32'(0));
            end
        end
    endtask

    task automatic drive_rx_frame(input logic [uart_pkg::data_w-1:0] data,
                                  input logic stop_level);
        int p;
        p = int'(cfg.cbp) + 1;
        rx_line = 1'b0;
        repeat (p) @(negedge clk_i);
        for (int b = 0; b < uart_pkg::data_w; b++) begin
            rx_line = data[b];                  // lsb first
            repeat (p) @(negedge clk_i);
        end
        rx_line = stop_level;
        repeat (p) @(negedge clk_i);
        rx_line = 1'b1;
    endtask

    task automatic rx_frame(input logic [uart_pkg::data_w-1:0] data, input logic stop_level);
        int p;
        int target;
        int waited;
        p = int'(cfg.cbp) + 1;
        target = rx_done_seen + 1;
        drive_rx_frame(data, stop_level);
        waited = 0;
        while (rx_done_seen < target && waited < 2 * p) begin
            @(negedge clk_i);
            waited++;
        end
        if (rx_done_seen < target) begin
            $display("receiver gave no rx_done after a frame at %0d ns", $time);
            $display("FAIL: see errors above");
            $fatal(1, "receiver stuck");
        end
        exp_overrun = exp_overrun | exp_ready;
        exp_ready = 1'b1;
        exp_data = data;
        if (!stop_level) begin
            exp_frame_err = 1'b1;
        end
        check_rx_status();
        repeat (p) @(negedge clk_i);            // idle gap on the line
        check_value("rx_done count", 32'(rx_done_seen), 32'(target));
    endtask

    task automatic read_rx();
        rx_read = 1'b1;
        @(negedge clk_i);
        rx_read = 1'b0;
        exp_ready = 1'b0;
        exp_overrun = 1'b0;
        exp_frame_err = 1'b0;
        check_rx_status();
    endtask

    initial begin
        void'($urandom(32'haa47));
        rst_i = 1'b1;
        cfg.cbp = 16'(3 + $urandom % (max_cbp - 2));
        cfg.stop_bits = uart_pkg::stop_one;
        tx_start = 1'b0;
        tx_data = '0;
        rx_read = 1'b0;
        rx_line = 1'b1;
        exp_ready = 1'b0;
        exp_overrun = 1'b0;
        exp_frame_err = 1'b0;
        exp_data = '0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;

        check_value("tx_o after reset", 32'(tx_line), 32'(1));
        check_value("tx_busy after reset", 32'(status.tx_busy), 32'(0));
        check_value("tx_done after reset", 32'(status.tx_done), 32'(0));
        check_rx_status();

        for (int r = 0; r < n_rounds; r++) begin
            cfg.cbp = 16'(3 + $urandom % (max_cbp - 2));
            for (int k = 0; k < 4; k++) begin
                cfg.stop_bits = ($urandom % 2 == 1) ? uart_pkg::stop_two : uart_pkg::stop_one;
                tx_frame(8'($urandom), k == 3);
            end
            for (int k = 0; k < 3; k++) begin
                rx_frame(8'($urandom), 1'b1);
                read_rx();
            end
            rx_frame(8'($urandom), 1'b0);       // low stop bit
            read_rx();
            rx_frame(8'($urandom), 1'b1);
            rx_frame(8'($urandom), 1'b1);       // second byte overwrites the first
            read_rx();
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* list.f */
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_status.sv
verilog/uart_top.sv
bench/uart_assert.sv
bench/uart_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build uart_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module uart_tb -Mdir obj_dir -f list.f
	-./obj_dir/Vuart_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || { echo "test failed, run did not finish"; exit 1; }
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
